// ==== design/paj_pkg.sv ====
`default_nettype none

package paj_pkg;

   //////////////////////////////
   // Bus timing
   //////////////////////////////
   localparam int STABLE_CYCLES = 64;            // Power-up wait
   localparam int SCL_PERIOD    = 20;            // Clocks per SCL period
   localparam int SCL_HIGH      = 10;            // High phase leads
   localparam int SDA_SETUP     = 4;             // Into high region
   localparam int STOP_WAIT     = 100;           // Inter-frame gap
   localparam int BYTE_BITS     = 8;

   //////////////////////////////
   // Sensor
   //////////////////////////////
   localparam logic [6:0] SLAVE_ADDRESS = 7'h73;
   localparam int NUM_REGS = 2;
   localparam logic [NUM_REGS-1:0][7:0] REG_LIST = {8'h02, 8'h01};  // Index 0 read first

   // Counter widths
   localparam int STABLE_CNT_W = $clog2(STABLE_CYCLES + 1);
   localparam int SCL_CNT_W    = $clog2(SCL_PERIOD);
   localparam int BIT_CNT_W    = $clog2(BYTE_BITS);
   localparam int WAIT_CNT_W   = $clog2(STOP_WAIT + 1);
   localparam int FRAME_CNT_W  = $clog2(NUM_REGS + 1);
   localparam int REG_IDX_W    = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

   typedef enum logic [3:0]
   {
      IDLE,
      START,
      SLAVE_ADDR,
      SLAVE_ACK,
      REG_ADDR,
      REP_START,
      DATA_READ,
      MASTER_NACK,
      STOP,
      DONE
   } i2c_state_e;

   typedef enum logic
   {
      RW_WRITE = 1'b0,
      RW_READ  = 1'b1
   } rw_e;

   typedef struct packed
   {
      logic scl;
      logic rise;                                // One cycle after SCL goes high
      logic fall;
      logic high_region;
   } scl_timing_t;

   typedef struct packed
   {
      logic [7:0] reg_addr;
      logic       last;                          // Final frame of the list
   } frame_cmd_t;

   typedef struct packed
   {
      logic [7:0] reg_addr;
      logic [7:0] data;
   } read_result_t;

endpackage

`default_nettype wire

// ==== design/power_up_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module power_up_timer
(
   input  wire  Clk_i,
   input  wire  Reset_i,
   input  wire  Switch_i,
   output logic Stable_o
);

   logic [paj_pkg::STABLE_CNT_W-1:0] count_r;
   logic                             stable_r;

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         count_r <= '0;
      end
      else if (Switch_i && count_r < paj_pkg::STABLE_CYCLES)
      begin
         count_r <= count_r + 1'b1;             // Holds if switch drops
      end
   end

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         stable_r <= 1'b0;
      end
      else if (count_r == paj_pkg::STABLE_CYCLES)
      begin
         stable_r <= 1'b1;                      // Sticky until reset
      end
   end

   assign Stable_o = stable_r;

endmodule

`default_nettype wire

// ==== design/scl_generator.sv ====
`timescale 1ns/100ps
`default_nettype none

module scl_generator
(
   input  wire                  Clk_i,
   input  wire                  Reset_i,
   input  wire                  Run_i,
   output paj_pkg::scl_timing_t Scl_timing_o
);

   logic [paj_pkg::SCL_CNT_W-1:0] period_cnt_r;
   logic                          scl;
   logic                          scl_d_r;
   logic                          rise_r;
   logic                          fall_r;
   logic                          high_region_r;

   //////////////////////////////
   // Period counter
   //////////////////////////////
   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         period_cnt_r <= '0;
      end
      else if (!Run_i)
      begin
         period_cnt_r <= '0;                    // Parks SCL high
      end
      else if (period_cnt_r == paj_pkg::SCL_PERIOD - 1)
      begin
         period_cnt_r <= '0;
      end
      else
      begin
         period_cnt_r <= period_cnt_r + 1'b1;
      end
   end

   assign scl = (period_cnt_r < paj_pkg::SCL_HIGH);

   //////////////////////////////
   // Edge detection
   //////////////////////////////
   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         scl_d_r       <= 1'b1;
         rise_r        <= 1'b0;
         fall_r        <= 1'b0;
         high_region_r <= 1'b1;                 // Bus idles high
      end
      else
      begin
         scl_d_r <= scl;
         rise_r  <= scl && !scl_d_r;
         fall_r  <= !scl && scl_d_r;
         if (scl && !scl_d_r)
         begin
            high_region_r <= 1'b1;
         end
         else if (!scl && scl_d_r)
         begin
            high_region_r <= 1'b0;
         end
      end
   end

   assign Scl_timing_o = '{scl: scl, rise: rise_r, fall: fall_r, high_region: high_region_r};

   // No SCL level shorter than two clocks
   a_edges_exclusive: assert property (@(posedge Clk_i) disable iff (!Reset_i)
      (rise_r || fall_r) |=> !(rise_r || fall_r));

endmodule

`default_nettype wire

// ==== design/read_sequence_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_sequence_regs
(
   input  wire                 Clk_i,
   input  wire                 Reset_i,
   input  wire                 Frame_end_i,
   input  wire paj_pkg::rw_e   Rw_i,
   output paj_pkg::frame_cmd_t Frame_cmd_o,
   output logic [7:0]          Slave_byte_o
);

   logic [paj_pkg::FRAME_CNT_W-1:0] frame_cnt_r;
   logic [paj_pkg::REG_IDX_W-1:0]   reg_idx;

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         frame_cnt_r <= '0;
      end
      else if (Frame_end_i && frame_cnt_r < paj_pkg::NUM_REGS)
      begin
         frame_cnt_r <= frame_cnt_r + 1'b1;     // Saturates at NUM_REGS
      end
   end

   // Register table lookup
   always_comb
   begin
      reg_idx              = frame_cnt_r[paj_pkg::REG_IDX_W-1:0];
      Frame_cmd_o.reg_addr = 8'hFF;             // Past the list
      Frame_cmd_o.last     = 1'b0;
      if (frame_cnt_r < paj_pkg::NUM_REGS)
      begin
         Frame_cmd_o.reg_addr = paj_pkg::REG_LIST[reg_idx];
         Frame_cmd_o.last     = (frame_cnt_r == paj_pkg::NUM_REGS - 1);
      end
   end

   assign Slave_byte_o = {paj_pkg::SLAVE_ADDRESS, Rw_i};  // Direction in bit 0

endmodule

`default_nettype wire

// ==== design/i2c_read_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module i2c_read_fsm
(
   input  wire                       Clk_i,
   input  wire                       Reset_i,
   input  wire                       Power_stable_i,
   input  wire                       Sda_i,
   input  wire paj_pkg::scl_timing_t Scl_timing_i,
   input  wire paj_pkg::frame_cmd_t  Frame_cmd_i,
   input  wire [7:0]                 Slave_byte_i,
   output logic                      Scl_run_o,
   output logic                      Sda_low_o,
   output paj_pkg::rw_e              Rw_o,
   output logic                      Frame_end_o,
   output logic                      Read_valid_o,
   output logic                      Data_available_o,
   output logic                      Seq_done_o,
   output paj_pkg::read_result_t     Read_result_o
);

   paj_pkg::i2c_state_e              state_r;
   paj_pkg::i2c_state_e              ack_phase_r;   // Byte before the ack slot
   paj_pkg::rw_e                     rw_r;
   paj_pkg::read_result_t            result_r;
   logic                             scl_run_r;
   logic                             sda_low_r;
   logic [paj_pkg::BIT_CNT_W-1:0]    bit_cnt_r;
   logic [paj_pkg::WAIT_CNT_W-1:0]   wait_cnt_r;
   logic [paj_pkg::BYTE_BITS-1:0]    tx_r;
   logic [paj_pkg::BYTE_BITS-1:0]    rx_r;
   logic                             frame_end_r;
   logic                             read_valid_r;
   logic                             data_available_r;
   logic                             seq_done_r;

   always_ff @(posedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         state_r          <= paj_pkg::IDLE;
         ack_phase_r      <= paj_pkg::SLAVE_ADDR;
         rw_r             <= paj_pkg::RW_WRITE;
         result_r         <= '0;
         scl_run_r        <= 1'b0;
         sda_low_r        <= 1'b0;
         bit_cnt_r        <= '0;
         wait_cnt_r       <= '0;
         tx_r             <= '0;
         rx_r             <= '0;
         frame_end_r      <= 1'b0;
         read_valid_r     <= 1'b0;
         data_available_r <= 1'b0;
         seq_done_r       <= 1'b0;
      end
      else
      begin
         frame_end_r      <= 1'b0;              // Pulses
         read_valid_r     <= 1'b0;
         data_available_r <= 1'b0;
         case (state_r)
            paj_pkg::IDLE:
            begin
               if (Power_stable_i)
               begin
                  state_r    <= paj_pkg::START;
                  rw_r       <= paj_pkg::RW_WRITE;
                  wait_cnt_r <= '0;
               end
            end
            paj_pkg::START:
            begin
               if (!scl_run_r && Scl_timing_i.high_region)
               begin
                  wait_cnt_r <= wait_cnt_r + 1'b1;
                  if (wait_cnt_r == paj_pkg::SDA_SETUP - 1)
                  begin
                     sda_low_r <= 1'b1;         // SDA falls under high SCL
                     scl_run_r <= 1'b1;
                  end
               end
               else if (scl_run_r && Scl_timing_i.fall)
               begin
                  state_r   <= paj_pkg::SLAVE_ADDR;
                  sda_low_r <= !Slave_byte_i[7];
                  tx_r      <= {Slave_byte_i[6:0], 1'b0};
                  bit_cnt_r <= '0;
               end
            end
            //////////////////////////////
            // Byte shift out, MSB first
            //////////////////////////////
            paj_pkg::SLAVE_ADDR, paj_pkg::REG_ADDR:
            begin
               if (Scl_timing_i.fall)
               begin
                  if (bit_cnt_r == paj_pkg::BYTE_BITS - 1)
                  begin
                     state_r     <= paj_pkg::SLAVE_ACK;
                     ack_phase_r <= state_r;
                     sda_low_r   <= 1'b0;       // Release for slave ack
                  end
                  else
                  begin
                     sda_low_r <= !tx_r[paj_pkg::BYTE_BITS-1];
                     tx_r      <= tx_r << 1;
                     bit_cnt_r <= bit_cnt_r + 1'b1;
                  end
               end
            end
            paj_pkg::SLAVE_ACK:
            begin
               if (Scl_timing_i.fall)
               begin
                  bit_cnt_r <= '0;
                  if (ack_phase_r == paj_pkg::REG_ADDR)
                  begin
                     state_r <= paj_pkg::REP_START;
                     rw_r    <= paj_pkg::RW_READ;
                  end
                  else if (rw_r == paj_pkg::RW_WRITE)
                  begin
                     state_r   <= paj_pkg::REG_ADDR;
                     sda_low_r <= !Frame_cmd_i.reg_addr[7];
                     tx_r      <= {Frame_cmd_i.reg_addr[6:0], 1'b0};
                  end
                  else
                  begin
                     state_r <= paj_pkg::DATA_READ;
                  end
               end
            end
            paj_pkg::REP_START:
            begin
               if (Scl_timing_i.rise)
               begin
                  state_r    <= paj_pkg::START;
                  scl_run_r  <= 1'b0;           // Hold SCL high
                  wait_cnt_r <= '0;
               end
            end
            paj_pkg::DATA_READ:
            begin
               if (Scl_timing_i.rise)
               begin
                  rx_r <= {rx_r[paj_pkg::BYTE_BITS-2:0], Sda_i};
               end
               if (Scl_timing_i.fall)
               begin
                  if (bit_cnt_r == paj_pkg::BYTE_BITS - 1)
                  begin
                     state_r <= paj_pkg::MASTER_NACK;  // SDA stays released
                  end
                  else
                  begin
                     bit_cnt_r <= bit_cnt_r + 1'b1;
                  end
               end
            end
            paj_pkg::MASTER_NACK:
            begin
               if (Scl_timing_i.fall)
               begin
                  state_r    <= paj_pkg::STOP;
                  sda_low_r  <= 1'b1;
                  wait_cnt_r <= '0;
               end
            end
            //////////////////////////////
            // Stop and inter-frame wait
            //////////////////////////////
            paj_pkg::STOP:
            begin
               if (Scl_timing_i.rise)
               begin
                  scl_run_r <= 1'b0;
               end
               if (Scl_timing_i.high_region)
               begin
                  wait_cnt_r <= wait_cnt_r + 1'b1;
                  if (wait_cnt_r == paj_pkg::SDA_SETUP - 1)
                  begin
                     sda_low_r        <= 1'b0;  // SDA rises under high SCL
                     read_valid_r     <= 1'b1;
                     result_r         <= '{reg_addr: Frame_cmd_i.reg_addr, data: rx_r};
                     data_available_r <= Frame_cmd_i.last;
                     if (Frame_cmd_i.last)
                     begin
                        seq_done_r <= 1'b1;
                     end
                  end
                  if (wait_cnt_r == paj_pkg::STOP_WAIT - 1)
                  begin
                     frame_end_r <= 1'b1;
                     if (Frame_cmd_i.last)
                     begin
                        state_r <= paj_pkg::DONE;
                     end
                     else
                     begin
                        state_r <= paj_pkg::IDLE;
                     end
                  end
               end
            end
            paj_pkg::DONE:
            begin
               state_r <= paj_pkg::DONE;        // Halts until reset
            end
            default:
            begin
               state_r <= paj_pkg::IDLE;
            end
         endcase
      end
   end

   assign Scl_run_o        = scl_run_r;
   assign Sda_low_o        = sda_low_r;
   assign Rw_o             = rw_r;
   assign Frame_end_o      = frame_end_r;
   assign Read_valid_o     = read_valid_r;
   assign Data_available_o = data_available_r;
   assign Seq_done_o       = seq_done_r;
   assign Read_result_o    = result_r;

   // SDA only moves under high SCL for start, repeated start and stop
   a_sda_stable_scl_high: assert property (@(posedge Clk_i) disable iff (!Reset_i)
      (Scl_timing_i.scl && $past(Scl_timing_i.scl) && sda_low_r != $past(sda_low_r))
      |-> ($past(state_r) inside {paj_pkg::START, paj_pkg::REP_START, paj_pkg::STOP}));

   a_valid_after_stop: assert property (@(posedge Clk_i) disable iff (!Reset_i)
      read_valid_r |-> (state_r == paj_pkg::STOP && !sda_low_r && Scl_timing_i.scl));

endmodule

`default_nettype wire

// ==== design/paj_reader_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module paj_reader_top
(
   input  wire                   Clk_i,
   input  wire                   Reset_i,
   input  wire                   Switch_i,
   input  wire                   Sda_i,
   output logic                  Scl_o,
   output logic                  Sda_low_o,
   output logic                  Read_valid_o,
   output logic                  Data_available_o,
   output logic                  Seq_done_o,
   output paj_pkg::read_result_t Read_result_o
);

   logic                 power_stable;
   logic                 scl_run;
   logic                 frame_end;
   logic [7:0]           slave_byte;
   paj_pkg::rw_e         rw;
   paj_pkg::scl_timing_t scl_timing;
   paj_pkg::frame_cmd_t  frame_cmd;

   power_up_timer power_up_timer0
   (
      .Clk_i    (Clk_i),
      .Reset_i  (Reset_i),
      .Switch_i (Switch_i),
      .Stable_o (power_stable)
   );

   scl_generator scl_generator0
   (
      .Clk_i        (Clk_i),
      .Reset_i      (Reset_i),
      .Run_i        (scl_run),
      .Scl_timing_o (scl_timing)
   );

   read_sequence_regs read_sequence_regs0
   (
      .Clk_i        (Clk_i),
      .Reset_i      (Reset_i),
      .Frame_end_i  (frame_end),
      .Rw_i         (rw),
      .Frame_cmd_o  (frame_cmd),
      .Slave_byte_o (slave_byte)
   );

   i2c_read_fsm i2c_read_fsm0
   (
      .Clk_i            (Clk_i),
      .Reset_i          (Reset_i),
      .Power_stable_i   (power_stable),
      .Sda_i            (Sda_i),
      .Scl_timing_i     (scl_timing),
      .Frame_cmd_i      (frame_cmd),
      .Slave_byte_i     (slave_byte),
      .Scl_run_o        (scl_run),
      .Sda_low_o        (Sda_low_o),
      .Rw_o             (rw),
      .Frame_end_o      (frame_end),
      .Read_valid_o     (Read_valid_o),
      .Data_available_o (Data_available_o),
      .Seq_done_o       (Seq_done_o),
      .Read_result_o    (Read_result_o)
   );

   assign Scl_o = scl_timing.scl;

endmodule

`default_nettype wire

// ==== verification/paj_reader_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module paj_reader_tb;

   localparam int IDLE_CYCLES  = 200;
   localparam int QUIET_CYCLES = 500;
   localparam int RESET_CYCLES = 4;
   localparam int FRAME_CYCLES = 36 * paj_pkg::SCL_PERIOD + paj_pkg::STOP_WAIT;
   localparam int SEQ_CYCLES   = paj_pkg::STABLE_CYCLES + 1 + paj_pkg::NUM_REGS * FRAME_CYCLES;
   localparam int TIMEOUT_CYCLES =
      (2 * RESET_CYCLES + IDLE_CYCLES + QUIET_CYCLES + 2 * SEQ_CYCLES) * 6 / 5;

   // Slave phases
   localparam int P_IDLE      = 0;
   localparam int P_WADDR     = 1;
   localparam int P_REG       = 2;
   localparam int P_WAIT_RS   = 3;
   localparam int P_RADDR     = 4;
   localparam int P_DATA      = 5;
   localparam int P_WAIT_STOP = 6;

   logic                  Clk_i;
   logic                  Reset_i;
   logic                  Switch_i;
   logic                  slave_low = 1'b0;
   wire                   sda_bus;
   logic                  Scl_o;
   logic                  Sda_low_o;
   logic                  Read_valid_o;
   logic                  Data_available_o;
   logic                  Seq_done_o;
   paj_pkg::read_result_t Read_result_o;
   paj_pkg::read_result_t last_result;

   logic [7:0] vec_mem [0:15];                  // Frame count, then reg/data pairs
   int         err [1:6];
   int         cycle_cnt = 0;
   int         starts_seen = 0;
   int         s_phase;
   int         s_bits;
   int         s_frame;
   logic [7:0] s_rx;
   logic [7:0] s_tx;
   logic       scl_prev;
   logic       sda_prev;
   int         valid_cnt;
   int         avail_cnt;

   assign sda_bus = !Sda_low_o && !slave_low;   // Wired-AND bus line

   paj_reader_top dut0
   (
      .Clk_i            (Clk_i),
      .Reset_i          (Reset_i),
      .Switch_i         (Switch_i),
      .Sda_i            (sda_bus),
      .Scl_o            (Scl_o),
      .Sda_low_o        (Sda_low_o),
      .Read_valid_o     (Read_valid_o),
      .Data_available_o (Data_available_o),
      .Seq_done_o       (Seq_done_o),
      .Read_result_o    (Read_result_o)
   );

   task automatic report_mismatch(input int test, input string sig, input logic [15:0] got,
                                  input logic [15:0] exp);
      $display("FAILED test %0d: %s = %h, expected %h", test, sig, got, exp);
      err[test]++;
   endtask

   task automatic report_event(input int test, input string what);
      $display("Error in test %0d: %s", test, what);
      err[test]++;
   endtask

   task automatic finish_test(input int test, input string name);
      $display("test %0d %s: %0d errors", test, name, err[test]);
   endtask

   function automatic logic [7:0] expected_reg(input int idx);
      return vec_mem[1 + 2 * idx];
   endfunction

   function automatic logic [7:0] expected_data(input int idx);
      return vec_mem[2 + 2 * idx];
   endfunction

   function automatic logic expected_data_msb(input int idx);
      logic [7:0] data;
      data = expected_data(idx);
      return data[7];
   endfunction

   function automatic logic [7:0] expected_byte(input int phase, input int frame);
      if (phase == P_WADDR)
         return 8'hE6;                          // Sensor address, write
      else if (phase == P_REG)
         return expected_reg(frame);
      return 8'hE7;                             // Sensor address, read
   endfunction

   initial
   begin
      Clk_i = 1'b0;
      forever #2 Clk_i = ~Clk_i;
   end

   always @(posedge Clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES)
      begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Behavioral I2C slave
   //////////////////////////////
   always @(negedge Clk_i or negedge Reset_i)
   begin
      if (!Reset_i)
      begin
         s_phase   <= P_IDLE;
         s_bits    <= 0;
         s_frame   <= 0;
         s_rx      <= '0;
         s_tx      <= '0;
         slave_low <= 1'b0;
         scl_prev  <= 1'b1;
         sda_prev  <= 1'b1;
      end
      else
      begin
         scl_prev <= Scl_o;
         sda_prev <= sda_bus;
         if (Scl_o && scl_prev && sda_bus != sda_prev)
         begin
            if (!sda_bus)                       // Start or repeated start
            begin
               assert (s_phase == P_IDLE || s_phase == P_WAIT_RS)
               else report_event(5, "SDA fell under high SCL in the middle of a transfer");
               starts_seen <= starts_seen + 1;
               s_phase     <= (s_phase == P_WAIT_RS) ? P_RADDR : P_WADDR;
               s_bits      <= 0;
            end
            else
            begin
               assert (s_phase == P_WAIT_STOP)
               else report_event(5, "SDA rose under high SCL before the not-acknowledge clock");
               s_phase <= P_IDLE;
               s_frame <= s_frame + 1;
            end
         end
         else if (Scl_o && !scl_prev && s_phase inside {P_WADDR, P_REG, P_RADDR, P_DATA})
         begin
            s_bits <= s_bits + 1;
            if (s_bits < 8)
               s_rx <= {s_rx[6:0], sda_bus};
         end
         else if (!Scl_o && scl_prev && s_phase == P_DATA)
         begin
            if (s_bits < 8)
               slave_low <= !s_tx[7 - s_bits];
            else if (s_bits == 8)
               slave_low <= 1'b0;               // Master owns the nack slot
            else
               s_phase <= P_WAIT_STOP;
         end
         else if (!Scl_o && scl_prev && s_phase inside {P_WADDR, P_REG, P_RADDR})
         begin
            if (s_bits == 8)
            begin
               assert (s_rx == expected_byte(s_phase, s_frame))
               else report_mismatch(2, "slave rx byte", 16'(s_rx),
                                    16'(expected_byte(s_phase, s_frame)));
               slave_low <= 1'b1;               // Ack
            end
            else if (s_bits == 9)
            begin
               slave_low <= 1'b0;
               s_bits    <= 0;
               if (s_phase == P_WADDR)
                  s_phase <= P_REG;
               else if (s_phase == P_REG)
                  s_phase <= P_WAIT_RS;
               else
               begin
                  s_phase   <= P_DATA;
                  s_tx      <= expected_data(s_frame);
                  slave_low <= !expected_data_msb(s_frame);
               end
            end
         end
      end
   end

   //////////////////////////////
   // Read result monitor
   //////////////////////////////
   always @(negedge Clk_i)
   begin
      if (!Reset_i)
      begin
         valid_cnt <= 0;
         avail_cnt <= 0;
      end
      else
      begin
         if (Read_valid_o)
         begin
            assert (valid_cnt < paj_pkg::NUM_REGS)
            else report_event(3, "Read_valid_o pulsed after the last frame");
            assert (Read_result_o.reg_addr == expected_reg(valid_cnt))
            else report_mismatch(3, "Read_result_o.reg_addr", 16'(Read_result_o.reg_addr),
                                 16'(expected_reg(valid_cnt)));
            assert (Read_result_o.data == expected_data(valid_cnt))
            else report_mismatch(3, "Read_result_o.data", 16'(Read_result_o.data),
                                 16'(expected_data(valid_cnt)));
            assert (Data_available_o == (valid_cnt == paj_pkg::NUM_REGS - 1))
            else report_mismatch(4, "Data_available_o", 16'(Data_available_o),
                                 16'(valid_cnt == paj_pkg::NUM_REGS - 1));
            valid_cnt   <= valid_cnt + 1;
            last_result <= Read_result_o;
         end
         else
         begin
            assert (!Data_available_o)
            else report_event(4, "Data_available_o pulsed without Read_valid_o");
         end
         if (Data_available_o)
            avail_cnt <= avail_cnt + 1;
      end
   end

   initial
   begin
      int starts_before;
      int total;
      Reset_i  = 1'b0;
      Switch_i = 1'b0;
      for (int i = 1; i <= 6; i++)
         err[i] = 0;
      $readmemh("verification/paj_reader_vectors.txt", vec_mem);
      assert (vec_mem[0] == paj_pkg::NUM_REGS)
      else report_event(3, "frame count in the vector file does not match NUM_REGS");
      repeat (RESET_CYCLES) @(negedge Clk_i);
      Reset_i = 1'b1;

      repeat (IDLE_CYCLES)
      begin
         @(negedge Clk_i);
         assert (Scl_o) else report_mismatch(1, "Scl_o", 16'(Scl_o), 16'h1);
         assert (!Sda_low_o) else report_mismatch(1, "Sda_low_o", 16'(Sda_low_o), 16'h0);
      end
      assert (starts_seen == 0) else report_event(1, "start seen with Switch_i low");
      finish_test(1, "idle hold");

      // Reset in the middle of the second frame
      Switch_i = 1'b1;
      while (!(s_phase == P_REG && s_frame == 1))
         @(negedge Clk_i);
      Reset_i = 1'b0;
      @(negedge Clk_i);
      assert (Scl_o) else report_mismatch(6, "Scl_o", 16'(Scl_o), 16'h1);
      assert (!Sda_low_o) else report_mismatch(6, "Sda_low_o", 16'(Sda_low_o), 16'h0);
      assert (!Read_valid_o) else report_mismatch(6, "Read_valid_o", 16'(Read_valid_o), 16'h0);
      assert (!Data_available_o)
      else report_mismatch(6, "Data_available_o", 16'(Data_available_o), 16'h0);
      assert (!Seq_done_o) else report_mismatch(6, "Seq_done_o", 16'(Seq_done_o), 16'h0);
      repeat (RESET_CYCLES - 1) @(negedge Clk_i);
      Reset_i = 1'b1;
      while (valid_cnt == 0)
         @(negedge Clk_i);
      assert (last_result.reg_addr == expected_reg(0))
      else report_mismatch(6, "Read_result_o.reg_addr", 16'(last_result.reg_addr),
                           16'(expected_reg(0)));
      finish_test(6, "restart");

      while (!Seq_done_o)
         @(negedge Clk_i);
      starts_before = starts_seen;
      repeat (QUIET_CYCLES)
      begin
         @(negedge Clk_i);
         assert (Seq_done_o) else report_mismatch(4, "Seq_done_o", 16'(Seq_done_o), 16'h1);
         assert (Scl_o) else report_mismatch(4, "Scl_o", 16'(Scl_o), 16'h1);
         assert (!Sda_low_o) else report_mismatch(4, "Sda_low_o", 16'(Sda_low_o), 16'h0);
      end
      assert (starts_seen == starts_before) else report_event(4, "start after sequence end");
      assert (s_frame == paj_pkg::NUM_REGS)
      else report_mismatch(2, "frames stopped", 16'(s_frame), 16'(paj_pkg::NUM_REGS));
      finish_test(2, "addressing");
      assert (valid_cnt == paj_pkg::NUM_REGS)
      else report_mismatch(3, "Read_valid_o count", 16'(valid_cnt), 16'(paj_pkg::NUM_REGS));
      finish_test(3, "read data");
      assert (avail_cnt == 1)
      else report_mismatch(4, "Data_available_o count", 16'(avail_cnt), 16'h1);
      finish_test(4, "completion");
      finish_test(5, "bus rule");

      total = 0;
      for (int i = 1; i <= 6; i++)
         total += err[i];
      $display("6 tests run, %0d errors", total);
      if (total == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verification/paj_reader_vectors.txt ====
// First value: number of frames
// Then one line per frame: register address, byte the slave returns
02
01 5A
02 C3

// ==== tb.f ====
design/paj_pkg.sv
design/power_up_timer.sv
design/scl_generator.sv
design/read_sequence_regs.sv
design/i2c_read_fsm.sv
design/paj_reader_top.sv
verification/paj_reader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f \
   --top-module paj_reader_tb -o paj_reader_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/paj_reader_sim > "$LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$LOG"
   echo "Simulation exited with an error"
   exit 1
fi

cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
   exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
   echo "Simulation ended without a result"
   exit 1
fi

exit 0
